// File: list.f
verilog/tcp_tx_pkg.sv
verilog/tcp_tx_arb.sv
verilog/tcp_tx_cks.sv
verilog/tcp_tx_ser.sv
verilog/tcp_tx_top.sv
tests/tcp_tx_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tcp_tx_tb
FILELIST  = list.f
OBJDIR    = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: tests/tcp_tx_tb.sv
module tcp_tx_tb;
  import tcp_tx_pkg::*;

  localparam int          NUM_TESTS = 6;
  localparam logic [15:0] WINDOW    = 16'd1000;
  localparam logic [31:0] SEED      = 32'h13de_56bb;

  typedef struct packed {
    tcp_flags_t  flags;
    tcp_num_t    seq;
    tcp_num_t    ack;
    logic [15:0] len;
    logic [15:0] id;
    logic [15:0] cks_in;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] sport;
    logic [15:0] dport;
  } seg_t;

  logic clk;
  logic rst;
  logic [31:0] loc_ip;
  logic [31:0] rem_ip;
  logic [15:0] loc_port;
  logic [15:0] rem_port;
  tcp_stat_t   status;
  tcp_num_t    loc_seq;
  tcp_num_t    loc_ack;
  tcp_num_t    pld_seq;
  logic [15:0] pld_len;
  logic [15:0] pld_cks;
  logic        send_pld;
  logic        send_ka;
  logic        send_ack;
  logic        eng_req;
  tcp_flags_t  eng_flags;
  tcp_num_t    eng_seq;
  tcp_num_t    eng_ack;
  logic        hdr_rdy;
  logic        pld_sent;
  logic        ka_sent;
  logic        ack_sent;
  logic        eng_sent;
  logic [7:0]  hdr_dat;
  logic        hdr_val;
  logic        hdr_last;

  logic [31:0]  lfsr;
  logic [31:0]  stall_lfsr;
  logic         stall_en;
  logic         eng_phase;
  seg_t         exp_mem [0:63];
  seg_t         model_seg;
  seg_t         exp_seg;
  logic         exp_valid;
  logic [15:0]  wr_cnt;
  logic [15:0]  rd_cnt;
  logic [5:0]   byte_cnt;
  logic [319:0] rx;
  ipv4_hdr_u    got_ip;
  tcp_hdr_u     got_tcp;
  logic         hdr_done;
  logic [15:0]  ip_chk;
  logic [15:0]  tcp_chk;
  int           prop_errs;
  int           flow_errs;
  int           errs_before;
  int           pass_cnt;
  int           fail_cnt;

  tcp_tx_top #(
    .WINDOW_SIZE (WINDOW)
  ) DUT (
    .clk (clk), .rst (rst), .loc_ip (loc_ip), .rem_ip (rem_ip),
    .loc_port (loc_port), .rem_port (rem_port), .status (status),
    .loc_seq (loc_seq), .loc_ack (loc_ack), .pld_seq (pld_seq),
    .pld_len (pld_len), .pld_cks (pld_cks), .send_pld (send_pld),
    .send_ka (send_ka), .send_ack (send_ack), .eng_req (eng_req),
    .eng_flags (eng_flags), .eng_seq (eng_seq), .eng_ack (eng_ack),
    .hdr_rdy (hdr_rdy), .pld_sent (pld_sent), .ka_sent (ka_sent),
    .ack_sent (ack_sent), .eng_sent (eng_sent), .hdr_dat (hdr_dat),
    .hdr_val (hdr_val), .hdr_last (hdr_last)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // each LFSR step adds one new bit at the bottom of v
  task automatic take_bits(input int n, inout logic [31:0] s, output logic [31:0] v);
    v = 32'd0;
    for (int i = 0; i < n; i++) begin
      s = lfsr_step(s);
      v = {v[30:0], s[0]};
    end
  endtask

  function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
    logic [16:0] s;
    s = {1'b0, a} + {1'b0, b};
    return s[15:0] + {15'd0, s[16]};
  endfunction

  task automatic value_error(input string msg);
    prop_errs = prop_errs + 1;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  task automatic flow_error(input string msg);
    flow_errs = flow_errs + 1;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (NUM_TESTS * 2000) @(posedge clk);
    $display("the run timed out after %0d cycles with segments still pending", NUM_TESTS * 2000);
    $display("Test failed");
    $finish;
  end

  // hdr_rdy is stalled on about one cycle in four while stall_en is set
  initial begin
    logic [31:0] v;
    logic        en;
    stall_lfsr = SEED;
    hdr_rdy = 1'b1;
    forever begin
      @(posedge clk);
      en = stall_en;
      #1;
      if (en) begin
        take_bits(2, stall_lfsr, v);
        hdr_rdy = (v[1:0] != 2'b00);
      end else begin
        hdr_rdy = 1'b1;
      end
    end
  end

  // reference model that stores one expected segment per sent pulse
  always @(negedge clk) begin
    if (!rst && (pld_sent || ka_sent || ack_sent || eng_sent)) begin
      model_seg.src_ip = loc_ip;
      model_seg.dst_ip = rem_ip;
      model_seg.sport  = loc_port;
      model_seg.dport  = rem_port;
      model_seg.id     = wr_cnt;
      model_seg.ack    = eng_sent ? eng_ack : loc_ack;
      model_seg.len    = 16'd40;
      model_seg.cks_in = 16'd0;
      if (pld_sent) begin
        model_seg.flags  = TCP_FLAG_PSH | TCP_FLAG_ACK;
        model_seg.seq    = pld_seq;
        model_seg.len    = pld_len + 16'd40;
        model_seg.cks_in = pld_cks;
      end else if (ka_sent) begin
        model_seg.flags = TCP_FLAG_ACK;
        model_seg.seq   = loc_seq - 32'd1;
      end else if (ack_sent) begin
        model_seg.flags = TCP_FLAG_ACK;
        model_seg.seq   = loc_seq;
      end else begin
        model_seg.flags = eng_flags;
        model_seg.seq   = eng_seq;
      end
      exp_mem[wr_cnt[5:0]] = model_seg;
      wr_cnt = wr_cnt + 16'd1;
    end
  end

  // byte collector
  always @(posedge clk) begin
    if (rst) begin
      byte_cnt  <= 6'd0;
      rd_cnt    <= 16'd0;
      hdr_done  <= 1'b0;
      exp_valid <= 1'b0;
    end else begin
      hdr_done <= 1'b0;
      if (hdr_val && hdr_rdy) begin
        rx <= {rx[311:0], hdr_dat};
        if (byte_cnt == 6'd39) begin
          {got_ip, got_tcp} <= {rx[311:0], hdr_dat};
          exp_seg   <= exp_mem[rd_cnt[5:0]];
          exp_valid <= (rd_cnt != wr_cnt);
          rd_cnt    <= rd_cnt + 16'd1;
          byte_cnt  <= 6'd0;
          hdr_done  <= 1'b1;
        end else begin
          byte_cnt <= byte_cnt + 6'd1;
        end
      end
    end
  end

  always_comb begin
    ip_chk = 16'h0000;
    for (int i = 0; i < 10; i++) begin
      ip_chk = ones_add(ip_chk, got_ip.w[i]);
    end
    tcp_chk = ones_add(got_ip.f.src_ip[31:16], got_ip.f.src_ip[15:0]);
    tcp_chk = ones_add(tcp_chk, got_ip.f.dst_ip[31:16]);
    tcp_chk = ones_add(tcp_chk, got_ip.f.dst_ip[15:0]);
    tcp_chk = ones_add(tcp_chk, {8'h00, got_ip.f.proto});
    tcp_chk = ones_add(tcp_chk, got_ip.f.length - 16'd20);
    for (int i = 0; i < 10; i++) begin
      tcp_chk = ones_add(tcp_chk, got_tcp.w[i]);
    end
    tcp_chk = ones_add(tcp_chk, exp_seg.cks_in);
  end

  exp_a: assert property (@(negedge clk) hdr_done |-> exp_valid)
    else value_error("a header arrived with no segment expected");
  ip_fixed_a: assert property (@(negedge clk) hdr_done |-> (got_ip.f.ver == 4'd4 &&
      got_ip.f.ihl == 4'd5 && got_ip.f.df && !got_ip.f.mf && got_ip.f.ttl == 8'd64 &&
      got_ip.f.proto == 8'd6))
    else value_error("fixed IPv4 fields are wrong");
  ip_addr_a: assert property (@(negedge clk) hdr_done |->
      (got_ip.f.src_ip == exp_seg.src_ip && got_ip.f.dst_ip == exp_seg.dst_ip))
    else value_error("IPv4 addresses differ from the connection");
  ip_len_a: assert property (@(negedge clk) hdr_done |-> got_ip.f.length == exp_seg.len)
    else value_error($sformatf("ipv4 length %0d, expected %0d", got_ip.f.length, exp_seg.len));
  ip_id_a: assert property (@(negedge clk) hdr_done |-> got_ip.f.id == exp_seg.id)
    else value_error($sformatf("ipv4 id %0d, expected %0d", got_ip.f.id, exp_seg.id));
  ports_a: assert property (@(negedge clk) hdr_done |->
      (got_tcp.f.src_port == exp_seg.sport && got_tcp.f.dst_port == exp_seg.dport))
    else value_error("TCP ports differ from the connection");
  seq_a: assert property (@(negedge clk) hdr_done |-> got_tcp.f.seq == exp_seg.seq)
    else value_error($sformatf("seq %h, expected %h", got_tcp.f.seq, exp_seg.seq));
  ack_a: assert property (@(negedge clk) hdr_done |-> got_tcp.f.ack == exp_seg.ack)
    else value_error($sformatf("ack %h, expected %h", got_tcp.f.ack, exp_seg.ack));
  flags_a: assert property (@(negedge clk) hdr_done |-> got_tcp.f.flags == exp_seg.flags)
    else value_error($sformatf("flags %h, expected %h", got_tcp.f.flags, exp_seg.flags));
  tcp_fixed_a: assert property (@(negedge clk) hdr_done |-> (got_tcp.f.offset == 4'd5 &&
      got_tcp.f.window == WINDOW && got_tcp.f.urg == 16'd0))
    else value_error("fixed TCP fields are wrong");
  ip_cks_a: assert property (@(negedge clk) hdr_done |-> ip_chk == 16'hffff)
    else value_error($sformatf("IPv4 header sums to %h", ip_chk));
  tcp_cks_a: assert property (@(negedge clk) hdr_done |-> tcp_chk == 16'hffff)
    else value_error($sformatf("TCP segment sums to %h", tcp_chk));
  last_a: assert property (@(negedge clk) (hdr_val && hdr_rdy) |->
      (hdr_last == (byte_cnt == 6'd39)))
    else value_error($sformatf("hdr_last %b at byte %0d", hdr_last, byte_cnt + 6'd1));
  eng_only_a: assert property (@(negedge clk) eng_phase |-> !pld_sent)
    else value_error("payload was sent while the connection was not established");

  task automatic set_line(input int kind, input logic v);
    case (kind)
      0: send_pld = v;
      1: send_ka  = v;
      2: send_ack = v;
      default: eng_req = v;
    endcase
  endtask

  function automatic logic sent_of(input int kind);
    case (kind)
      0: return pld_sent;
      1: return ka_sent;
      2: return ack_sent;
      default: return eng_sent;
    endcase
  endfunction

  // hold the line until its pulse, then keep it low for one cycle
  task automatic request(input int kind);
    set_line(kind, 1'b1);
    @(negedge clk);
    while (!sent_of(kind)) @(negedge clk);
    @(posedge clk);
    #1;
    set_line(kind, 1'b0);
    @(posedge clk);
    #1;
  endtask

  task automatic new_values();
    logic [31:0] v;
    take_bits(32, lfsr, v);
    loc_seq = v;
    take_bits(32, lfsr, v);
    loc_ack = v;
    take_bits(32, lfsr, v);
    pld_seq = v;
    take_bits(10, lfsr, v);
    pld_len = {6'd0, v[9:0]} + 16'd1;
    take_bits(16, lfsr, v);
    pld_cks = v[15:0];
  endtask

  task automatic close_test(input int num, input string name);
    while (rd_cnt != wr_cnt || hdr_val) @(posedge clk);
    repeat (2) @(posedge clk);
    #1;
    assert (byte_cnt == 6'd0) else flow_error("a partial header is left over");
    if (prop_errs + flow_errs == errs_before) begin
      pass_cnt = pass_cnt + 1;
      $display("test %0d %s: pass", num, name);
    end else begin
      fail_cnt = fail_cnt + 1;
      $display("test %0d %s: fail", num, name);
    end
    errs_before = prop_errs + flow_errs;
  endtask

  task automatic priority_order();
    int k;
    new_values();
    send_pld = 1'b1;
    send_ka  = 1'b1;
    send_ack = 1'b1;
    for (int n = 0; n < 3; n++) begin
      @(negedge clk);
      while (!(pld_sent || ka_sent || ack_sent)) @(negedge clk);
      k = pld_sent ? 0 : (ka_sent ? 1 : 2);
      assert (k == n) else flow_error($sformatf("request %0d served in slot %0d", k, n));
      @(posedge clk);
      #1;
      set_line(k, 1'b0);
    end
    close_test(1, "priority");
  endtask

  task automatic field_fill();
    logic [31:0] v;
    take_bits(32, lfsr, v);
    loc_ip = v;
    take_bits(32, lfsr, v);
    rem_ip = v;
    take_bits(32, lfsr, v);
    loc_port = v[31:16];
    rem_port = v[15:0];
    new_values();
    request(2);
    request(1);
    close_test(2, "field fill");
  endtask

  task automatic checksum_cover();
    for (int n = 0; n < 4; n++) begin
      new_values();
      request(0);
    end
    close_test(3, "checksums");
  endtask

  task automatic engine_path();
    logic [31:0] v;
    eng_phase = 1'b1;
    send_pld  = 1'b1;
    status    = tcp_connecting;
    eng_flags = TCP_FLAG_SYN;
    take_bits(32, lfsr, v);
    eng_seq = v;
    request(3);
    status    = tcp_closing;
    eng_flags = TCP_FLAG_FIN | TCP_FLAG_ACK;
    take_bits(32, lfsr, v);
    eng_ack = v;
    request(3);
    status    = tcp_closed;
    eng_flags = TCP_FLAG_RST;
    request(3);
    send_pld  = 1'b0;
    eng_phase = 1'b0;
    status    = tcp_connected;
    close_test(4, "engine path");
  endtask

  task automatic stall_stream();
    logic [31:0] v;
    stall_en = 1'b1;
    for (int n = 0; n < 12; n++) begin
      new_values();
      take_bits(8, lfsr, v);
      request(int'(v % 32'd3));
    end
    close_test(5, "back-pressure");
    stall_en = 1'b0;
  endtask

  task automatic id_sequence();
    for (int n = 0; n < 3; n++) begin
      request(2);
    end
    while (rd_cnt != wr_cnt || hdr_val) @(posedge clk);
    #1;
    assert (got_ip.f.id == rd_cnt - 16'd1)
      else flow_error($sformatf("last id %0d after %0d headers", got_ip.f.id, rd_cnt));
    close_test(6, "identification");
  endtask

  initial begin
    lfsr        = SEED;
    stall_en    = 1'b0;
    eng_phase   = 1'b0;
    wr_cnt      = 16'd0;
    prop_errs   = 0;
    flow_errs   = 0;
    errs_before = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    rst       = 1'b1;
    status    = tcp_connected;
    loc_ip    = 32'hc0a8_0001;
    rem_ip    = 32'hc0a8_0002;
    loc_port  = 16'd5000;
    rem_port  = 16'd80;
    loc_seq   = 32'd0;
    loc_ack   = 32'd0;
    pld_seq   = 32'd0;
    pld_len   = 16'd0;
    pld_cks   = 16'd0;
    send_pld  = 1'b0;
    send_ka   = 1'b0;
    send_ack  = 1'b0;
    eng_req   = 1'b0;
    eng_flags = 9'd0;
    eng_seq   = 32'd0;
    eng_ack   = 32'd0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    priority_order();
    field_fill();
    checksum_cover();
    engine_path();
    stall_stream();
    id_sequence();
    $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && prop_errs + flow_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verilog/tcp_tx_top.sv
module tcp_tx_top #(
  parameter logic [15:0] WINDOW_SIZE = 16'd1000
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [31:0]            loc_ip,
  input  logic [31:0]            rem_ip,
  input  logic [15:0]            loc_port,
  input  logic [15:0]            rem_port,
  input  tcp_tx_pkg::tcp_stat_t  status,
  input  tcp_tx_pkg::tcp_num_t   loc_seq,
  input  tcp_tx_pkg::tcp_num_t   loc_ack,
  input  tcp_tx_pkg::tcp_num_t   pld_seq,
  input  logic [15:0]            pld_len,
  input  logic [15:0]            pld_cks,
  input  logic                   send_pld,
  input  logic                   send_ka,
  input  logic                   send_ack,
  input  logic                   eng_req,
  input  tcp_tx_pkg::tcp_flags_t eng_flags,
  input  tcp_tx_pkg::tcp_num_t   eng_seq,
  input  tcp_tx_pkg::tcp_num_t   eng_ack,
  input  logic                   hdr_rdy,
  output logic                   pld_sent,
  output logic                   ka_sent,
  output logic                   ack_sent,
  output logic                   eng_sent,
  output logic [7:0]             hdr_dat,
  output logic                   hdr_val,
  output logic                   hdr_last
);
  import tcp_tx_pkg::*;

  logic        a_rdy;
  logic        a_acc;
  ipv4_hdr_u   a_ip;
  tcp_hdr_u    a_tcp;
  logic [15:0] a_pld_cks;
  logic        c_rdy;
  logic        c_acc;
  ipv4_hdr_u   c_ip;
  tcp_hdr_u    c_tcp;

  tcp_tx_arb #(
    .WINDOW_SIZE (WINDOW_SIZE)
  ) u_arb (
    .clk       (clk),
    .rst       (rst),
    .status    (status),
    .loc_ip    (loc_ip),
    .rem_ip    (rem_ip),
    .loc_port  (loc_port),
    .rem_port  (rem_port),
    .loc_seq   (loc_seq),
    .loc_ack   (loc_ack),
    .pld_seq   (pld_seq),
    .pld_len   (pld_len),
    .pld_cks   (pld_cks),
    .send_pld  (send_pld),
    .send_ka   (send_ka),
    .send_ack  (send_ack),
    .eng_req   (eng_req),
    .eng_flags (eng_flags),
    .eng_seq   (eng_seq),
    .eng_ack   (eng_ack),
    .a_acc     (a_acc),
    .pld_sent  (pld_sent),
    .ka_sent   (ka_sent),
    .ack_sent  (ack_sent),
    .eng_sent  (eng_sent),
    .a_rdy     (a_rdy),
    .a_ip      (a_ip),
    .a_tcp     (a_tcp),
    .a_pld_cks (a_pld_cks)
  );

  tcp_tx_cks u_cks (
    .clk       (clk),
    .rst       (rst),
    .a_rdy     (a_rdy),
    .a_ip      (a_ip),
    .a_tcp     (a_tcp),
    .a_pld_cks (a_pld_cks),
    .c_acc     (c_acc),
    .a_acc     (a_acc),
    .c_rdy     (c_rdy),
    .c_ip      (c_ip),
    .c_tcp     (c_tcp)
  );

  tcp_tx_ser u_ser (
    .clk      (clk),
    .rst      (rst),
    .c_rdy    (c_rdy),
    .c_ip     (c_ip),
    .c_tcp    (c_tcp),
    .hdr_rdy  (hdr_rdy),
    .c_acc    (c_acc),
    .hdr_dat  (hdr_dat),
    .hdr_val  (hdr_val),
    .hdr_last (hdr_last)
  );

endmodule

// File: verilog/tcp_tx_ser.sv
module tcp_tx_ser (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  c_rdy,
  input  tcp_tx_pkg::ipv4_hdr_u c_ip,
  input  tcp_tx_pkg::tcp_hdr_u  c_tcp,
  input  logic                  hdr_rdy,
  output logic                  c_acc,
  output logic [7:0]            hdr_dat,
  output logic                  hdr_val,
  output logic                  hdr_last
);
  import tcp_tx_pkg::*;

  localparam int SH_W = HDR_BYTES * 8;

  logic [SH_W-1:0] sh;
  logic [5:0]      cnt;
  logic            xfer;

  // a new header is only taken once the previous one has fully left
  assign c_acc    = c_rdy && !hdr_val;
  assign xfer     = hdr_val && hdr_rdy;
  assign hdr_dat  = sh[SH_W-1 -: 8];
  assign hdr_last = hdr_val && (cnt == 6'(HDR_BYTES - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      hdr_val <= 1'b0;
      cnt     <= 6'd0;
    end else begin
      if (c_acc) begin
        hdr_val <= 1'b1;
        cnt     <= 6'd0;
      end else if (xfer) begin
        if (hdr_last) begin
          hdr_val <= 1'b0;
        end else begin
          cnt <= cnt + 6'd1;
        end
      end
    end
  end

  // IPv4 header sits in the upper half so it leaves first
  always_ff @(posedge clk) begin
    if (c_acc) begin
      sh <= {c_ip, c_tcp};
    end else if (xfer) begin
      sh <= {sh[SH_W-9:0], 8'h00};
    end
  end

endmodule

// File: verilog/tcp_tx_cks.sv
module tcp_tx_cks (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  a_rdy,
  input  tcp_tx_pkg::ipv4_hdr_u a_ip,
  input  tcp_tx_pkg::tcp_hdr_u  a_tcp,
  input  logic [15:0]           a_pld_cks,
  input  logic                  c_acc,
  output logic                  a_acc,
  output logic                  c_rdy,
  output tcp_tx_pkg::ipv4_hdr_u c_ip,
  output tcp_tx_pkg::tcp_hdr_u  c_tcp
);

  localparam logic [1:0] ST_EMPTY = 2'd0;
  localparam logic [1:0] ST_SUM   = 2'd1;
  localparam logic [1:0] ST_FOLD  = 2'd2;
  localparam logic [1:0] ST_FULL  = 2'd3;

  logic [1:0]  state;
  logic [3:0]  cnt;
  logic [15:0] pld_q;
  logic [19:0] ip_sum;
  logic [20:0] tcp_sum;
  logic [15:0] ip_word;
  logic [15:0] tcp_word;
  logic [3:0]  ip_idx;
  logic [3:0]  tcp_idx;

  // end-around carry twice, the second pass cannot carry again
  function automatic logic [15:0] fold_sum(input logic [20:0] s);
    logic [16:0] t;
    t = {1'b0, s[15:0]} + {12'h000, s[20:16]};
    return t[15:0] + {15'h0000, t[16]};
  endfunction

  assign ip_idx  = 4'd9 - cnt;
  assign tcp_idx = 4'd15 - cnt;

  // pseudo header first, then the TCP header words from the top down
  always_comb begin
    case (cnt)
      4'd0:    tcp_word = c_ip.f.src_ip[31:16];
      4'd1:    tcp_word = c_ip.f.src_ip[15:0];
      4'd2:    tcp_word = c_ip.f.dst_ip[31:16];
      4'd3:    tcp_word = c_ip.f.dst_ip[15:0];
      4'd4:    tcp_word = {8'h00, c_ip.f.proto};
      4'd5:    tcp_word = c_ip.f.length - 16'd20;
      default: tcp_word = c_tcp.w[tcp_idx];
    endcase
    ip_word = (cnt < 4'd10) ? c_ip.w[ip_idx] : 16'h0000;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_EMPTY;
      cnt   <= 4'd0;
      a_acc <= 1'b0;
      c_rdy <= 1'b0;
    end else begin
      a_acc <= 1'b0;
      case (state)
        ST_EMPTY: begin
          if (a_rdy) begin
            a_acc <= 1'b1;
            cnt   <= 4'd0;
            state <= ST_SUM;
          end
        end
        ST_SUM: begin
          cnt <= cnt + 4'd1;
          if (cnt == 4'd15) begin
            state <= ST_FOLD;
          end
        end
        ST_FOLD: begin
          c_rdy <= 1'b1;
          state <= ST_FULL;
        end
        default: begin
          if (c_acc) begin
            c_rdy <= 1'b0;
            state <= ST_EMPTY;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      ST_EMPTY: begin
        if (a_rdy) begin
          c_ip    <= a_ip;
          c_tcp   <= a_tcp;
          pld_q   <= a_pld_cks;
          ip_sum  <= 20'd0;
          tcp_sum <= 21'd0;
        end
      end
      ST_SUM: begin
        ip_sum  <= ip_sum + {4'h0, ip_word};
        tcp_sum <= tcp_sum + {5'h00, tcp_word};
      end
      ST_FOLD: begin
        c_ip.f.cks  <= ~fold_sum({1'b0, ip_sum});
        c_tcp.f.cks <= ~fold_sum(tcp_sum + {5'h00, pld_q});
      end
      default: ;
    endcase
  end

endmodule

// File: verilog/tcp_tx_arb.sv
module tcp_tx_arb #(
  parameter logic [15:0] WINDOW_SIZE = 16'd1000
) (
  input  logic                  clk,
  input  logic                  rst,
  input  tcp_tx_pkg::tcp_stat_t status,
  input  logic [31:0]           loc_ip,
  input  logic [31:0]           rem_ip,
  input  logic [15:0]           loc_port,
  input  logic [15:0]           rem_port,
  input  tcp_tx_pkg::tcp_num_t  loc_seq,
  input  tcp_tx_pkg::tcp_num_t  loc_ack,
  input  tcp_tx_pkg::tcp_num_t  pld_seq,
  input  logic [15:0]           pld_len,
  input  logic [15:0]           pld_cks,
  input  logic                  send_pld,
  input  logic                  send_ka,
  input  logic                  send_ack,
  input  logic                  eng_req,
  input  tcp_tx_pkg::tcp_flags_t eng_flags,
  input  tcp_tx_pkg::tcp_num_t  eng_seq,
  input  tcp_tx_pkg::tcp_num_t  eng_ack,
  input  logic                  a_acc,
  output logic                  pld_sent,
  output logic                  ka_sent,
  output logic                  ack_sent,
  output logic                  eng_sent,
  output logic                  a_rdy,
  output tcp_tx_pkg::ipv4_hdr_u a_ip,
  output tcp_tx_pkg::tcp_hdr_u  a_tcp,
  output logic [15:0]           a_pld_cks
);
  import tcp_tx_pkg::*;

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_ACTIVE = 2'd1;
  localparam logic [1:0] ST_SENT   = 2'd2;

  logic [1:0]  state;
  logic [3:0]  pick;
  logic [3:0]  kind;
  logic [15:0] id_cnt;
  logic        connected;
  logic        take;

  assign connected = (status == tcp_connected);

  // one-hot request select with bit order {eng, ack, ka, pld}
  always_comb begin
    pick = 4'b0000;
    if (connected) begin
      if (send_pld) begin
        pick = 4'b0001;
      end else if (send_ka) begin
        pick = 4'b0010;
      end else if (send_ack) begin
        pick = 4'b0100;
      end
    end else if (eng_req) begin
      pick = 4'b1000;
    end
  end

  assign take = (state == ST_IDLE) && (pick != 4'b0000);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      kind     <= 4'b0000;
      a_rdy    <= 1'b0;
      id_cnt   <= 16'd0;
      pld_sent <= 1'b0;
      ka_sent  <= 1'b0;
      ack_sent <= 1'b0;
      eng_sent <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (take) begin
            kind  <= pick;
            a_rdy <= 1'b1;
            state <= ST_ACTIVE;
          end
        end
        ST_ACTIVE: begin
          if (a_acc) begin
            a_rdy  <= 1'b0;
            {eng_sent, ack_sent, ka_sent, pld_sent} <= kind;
            id_cnt <= id_cnt + 16'd1;
            state  <= ST_SENT;
          end
        end
        ST_SENT: begin
          // requests are still high during the pulse, so this cycle is skipped
          {eng_sent, ack_sent, ka_sent, pld_sent} <= 4'b0000;
          state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      a_ip.f.ver      <= 4'd4;
      a_ip.f.ihl      <= 4'd5;
      a_ip.f.qos      <= 8'd0;
      a_ip.f.id       <= id_cnt;
      a_ip.f.rsv      <= 1'b0;
      a_ip.f.df       <= 1'b1;
      a_ip.f.mf       <= 1'b0;
      a_ip.f.fo       <= 13'd0;
      a_ip.f.ttl      <= IPV4_TTL;
      a_ip.f.proto    <= TCP_PROTO;
      a_ip.f.cks      <= 16'd0;
      a_ip.f.src_ip   <= loc_ip;
      a_ip.f.dst_ip   <= rem_ip;
      a_tcp.f.src_port <= loc_port;
      a_tcp.f.dst_port <= rem_port;
      a_tcp.f.ack      <= connected ? loc_ack : eng_ack;
      a_tcp.f.offset   <= TCP_HDR_OFFSET;
      a_tcp.f.rsv      <= 3'd0;
      a_tcp.f.window   <= WINDOW_SIZE;
      a_tcp.f.cks      <= 16'd0;
      a_tcp.f.urg      <= 16'd0;
      if (pick[0]) begin
        a_tcp.f.flags <= TCP_FLAG_PSH | TCP_FLAG_ACK;
        a_tcp.f.seq   <= pld_seq;
        a_ip.f.length <= pld_len + 16'(HDR_BYTES);
        a_pld_cks     <= pld_cks;
      end else begin
        a_ip.f.length <= 16'(HDR_BYTES);
        a_pld_cks     <= 16'd0;
        if (pick[1]) begin
          // keep-alive reuses the last acknowledged byte
          a_tcp.f.flags <= TCP_FLAG_ACK;
          a_tcp.f.seq   <= loc_seq - 32'd1;
        end else if (pick[2]) begin
          a_tcp.f.flags <= TCP_FLAG_ACK;
          a_tcp.f.seq   <= loc_seq;
        end else begin
          a_tcp.f.flags <= eng_flags;
          a_tcp.f.seq   <= eng_seq;
        end
      end
    end
  end

endmodule

// File: verilog/tcp_tx_pkg.sv
package tcp_tx_pkg;

  typedef logic [31:0] tcp_num_t;
  typedef logic [8:0]  tcp_flags_t;

  typedef enum logic [1:0] {
    tcp_closed,
    tcp_connecting,
    tcp_connected,
    tcp_closing
  } tcp_stat_t;

  localparam tcp_flags_t TCP_FLAG_FIN = 9'h001;
  localparam tcp_flags_t TCP_FLAG_SYN = 9'h002;
  localparam tcp_flags_t TCP_FLAG_RST = 9'h004;
  localparam tcp_flags_t TCP_FLAG_PSH = 9'h008;
  localparam tcp_flags_t TCP_FLAG_ACK = 9'h010;

  localparam logic [7:0] IPV4_TTL       = 8'd64;
  localparam logic [7:0] TCP_PROTO      = 8'd6;
  localparam logic [3:0] TCP_HDR_OFFSET = 4'd5;
  localparam int         HDR_BYTES      = 40;

  // field view for filling and sending, word view for the checksum adders
  typedef union packed {
    struct packed {
      logic [3:0]  ver;
      logic [3:0]  ihl;
      logic [7:0]  qos;
      logic [15:0] length;
      logic [15:0] id;
      logic        rsv;
      logic        df;
      logic        mf;
      logic [12:0] fo;
      logic [7:0]  ttl;
      logic [7:0]  proto;
      logic [15:0] cks;
      logic [31:0] src_ip;
      logic [31:0] dst_ip;
    } f;
    logic [9:0][15:0] w;
  } ipv4_hdr_u;

  typedef union packed {
    struct packed {
      logic [15:0] src_port;
      logic [15:0] dst_port;
      tcp_num_t    seq;
      tcp_num_t    ack;
      logic [3:0]  offset;
      logic [2:0]  rsv;
      tcp_flags_t  flags;
      logic [15:0] window;
      logic [15:0] cks;
      logic [15:0] urg;
    } f;
    logic [9:0][15:0] w;
  } tcp_hdr_u;

endpackage
